// ==== sram_access_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared widths, register map and bus/command structs
// command address field is fixed at 16 bits, modules use the low bits
//////////////////////////////////////////////////////////////////////

package sram_access_pkg;

   localparam int SRAM_DATA_WIDTH     = 36;
   localparam int CPCI_DATA_WIDTH     = 32;
   localparam int MSB_WIDTH           = SRAM_DATA_WIDTH - CPCI_DATA_WIDTH;
   localparam int REG_ADDR_WIDTH      = 4;
   localparam int CMD_ADDR_WIDTH      = 16;   // upper limit for SRAM_ADDR_WIDTH

   // cpu register map
   typedef enum logic [REG_ADDR_WIDTH-1:0] {
      SRAM1_MSB_RD = 4'd0,
      SRAM1_MSB_WR = 4'd1,
      SRAM2_MSB_RD = 4'd2,
      SRAM2_MSB_WR = 4'd3,
      SRAM_ADDR    = 4'd4,
      WR_DATA_LSB  = 4'd5,
      SRAM1_RD_LSB = 4'd6,
      SRAM2_RD_LSB = 4'd7,
      CMD          = 4'd8,
      STATUS       = 4'd9
   } reg_addr_e;

   // one ack per request level
   typedef enum logic {
      IDLE_STATE = 1'b0,
      DONE_STATE = 1'b1
   } reg_state_e;

   typedef struct packed {
      logic                       rd_wr_l;   // 1 = read
      logic [REG_ADDR_WIDTH-1:0]  addr;
      logic [CPCI_DATA_WIDTH-1:0] wr_data;
   } reg_req_t;

   typedef struct packed {
      logic                       bank;      // 0 = sram1
      logic                       we;
      logic [CMD_ADDR_WIDTH-1:0]  addr;
      logic [SRAM_DATA_WIDTH-1:0] data;
   } sram_cmd_t;

endpackage

// ==== reg_sram_msb.sv ====
//////////////////////////////////////////////////////////////////////
// msb access registers, answers register addresses 0 to 3 only
// request must be gated by the parent for other addresses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module reg_sram_msb (
   input  logic                                      clk,
   input  logic                                      reset,
   // cpu side
   input  logic                                      reg_req,
   input  sram_access_pkg::reg_req_t                 req,
   output logic                                      reg_ack,
   output logic [sram_access_pkg::CPCI_DATA_WIDTH-1:0] reg_rd_data,
   // sram controller side
   input  logic [sram_access_pkg::MSB_WIDTH-1:0]     s1_rd_data_msb,
   input  logic [sram_access_pkg::MSB_WIDTH-1:0]     s2_rd_data_msb,
   output logic [sram_access_pkg::MSB_WIDTH-1:0]     s1_wr_data_msb,
   output logic [sram_access_pkg::MSB_WIDTH-1:0]     s2_wr_data_msb
);

   sram_access_pkg::reg_state_e state, state_nxt;

   logic                                       reg_ack_nxt;
   logic [sram_access_pkg::CPCI_DATA_WIDTH-1:0] reg_rd_data_nxt;
   logic                                       s1_wr_sel;
   logic                                       s2_wr_sel;

   always_comb begin
      state_nxt       = state;
      reg_ack_nxt     = 1'b0;
      reg_rd_data_nxt = '0;
      s1_wr_sel       = 1'b0;
      s2_wr_sel       = 1'b0;

      case (state)
         sram_access_pkg::IDLE_STATE: begin
            if (reg_req) begin
               reg_ack_nxt = 1'b1;
               state_nxt   = sram_access_pkg::DONE_STATE;
               case (req.addr)
                  sram_access_pkg::SRAM1_MSB_RD:
                     reg_rd_data_nxt[sram_access_pkg::MSB_WIDTH-1:0] = s1_rd_data_msb;
                  sram_access_pkg::SRAM1_MSB_WR: begin
                     reg_rd_data_nxt[sram_access_pkg::MSB_WIDTH-1:0] = s1_wr_data_msb;
                     s1_wr_sel = 1'b1;
                  end
                  sram_access_pkg::SRAM2_MSB_RD:
                     reg_rd_data_nxt[sram_access_pkg::MSB_WIDTH-1:0] = s2_rd_data_msb;
                  sram_access_pkg::SRAM2_MSB_WR: begin
                     reg_rd_data_nxt[sram_access_pkg::MSB_WIDTH-1:0] = s2_wr_data_msb;
                     s2_wr_sel = 1'b1;
                  end
                  default: reg_rd_data_nxt = 32'hdeadbeef;
               endcase
            end
         end
         sram_access_pkg::DONE_STATE: begin
            if (!reg_req) state_nxt = sram_access_pkg::IDLE_STATE;   // wait for req to drop
         end
         default: state_nxt = sram_access_pkg::IDLE_STATE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= sram_access_pkg::IDLE_STATE;
         reg_ack        <= 1'b0;
         reg_rd_data    <= '0;
         s1_wr_data_msb <= '0;
         s2_wr_data_msb <= '0;
      end else begin
         state       <= state_nxt;
         reg_ack     <= reg_ack_nxt;
         reg_rd_data <= reg_rd_data_nxt;
         if (s1_wr_sel && !req.rd_wr_l)
            s1_wr_data_msb <= req.wr_data[sram_access_pkg::MSB_WIDTH-1:0];
         if (s2_wr_sel && !req.rd_wr_l)
            s2_wr_data_msb <= req.wr_data[sram_access_pkg::MSB_WIDTH-1:0];
      end
   end

endmodule

// ==== reg_sram_cmd.sv ====
//////////////////////////////////////////////////////////////////////
// cpu register block, addresses 4 to 9 here, 0 to 3 in the msb block
// a CMD write while the FIFO is full is acked but dropped and counted
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module reg_sram_cmd #(
   parameter int SRAM_ADDR_WIDTH = 6
) (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        reg_req,
   input  sram_access_pkg::reg_req_t                   req,
   output logic                                        reg_ack,
   output logic [sram_access_pkg::CPCI_DATA_WIDTH-1:0] reg_rd_data,
   input  logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] s1_rd_word,
   input  logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] s2_rd_word,
   input  logic                                        full,
   input  logic [2:0]                                  count,
   output logic                                        push,
   output sram_access_pkg::sram_cmd_t                  push_cmd
);

   localparam int DW = sram_access_pkg::CPCI_DATA_WIDTH;

   sram_access_pkg::reg_state_e state, state_nxt;

   logic                                   msb_range;
   logic                                   msb_ack;
   logic [DW-1:0]                          msb_rd_data;
   logic [sram_access_pkg::MSB_WIDTH-1:0] s1_wr_msb;
   logic [sram_access_pkg::MSB_WIDTH-1:0] s2_wr_msb;

   logic                       own_ack, own_ack_nxt;
   logic [DW-1:0]              own_rd_data, own_rd_data_nxt;
   logic                       addr_sel, data_sel, cmd_sel;
   logic [SRAM_ADDR_WIDTH-1:0] sram_addr;
   logic [DW-1:0]              wr_data_lsb;
   logic [7:0]                 drop_count;

   assign msb_range = (req.addr <= sram_access_pkg::SRAM2_MSB_WR);

   reg_sram_msb u_msb (
      .clk            (clk),
      .reset          (reset),
      .reg_req        (reg_req && msb_range),
      .req            (req),
      .reg_ack        (msb_ack),
      .reg_rd_data    (msb_rd_data),
      .s1_rd_data_msb (s1_rd_word[sram_access_pkg::SRAM_DATA_WIDTH-1:DW]),
      .s2_rd_data_msb (s2_rd_word[sram_access_pkg::SRAM_DATA_WIDTH-1:DW]),
      .s1_wr_data_msb (s1_wr_msb),
      .s2_wr_data_msb (s2_wr_msb)
   );

   // only one responder is active per request
   assign reg_ack     = msb_ack | own_ack;
   assign reg_rd_data = msb_rd_data | own_rd_data;

   always_comb begin
      state_nxt       = state;
      own_ack_nxt     = 1'b0;
      own_rd_data_nxt = '0;
      addr_sel        = 1'b0;
      data_sel        = 1'b0;
      cmd_sel         = 1'b0;
      case (state)
         sram_access_pkg::IDLE_STATE: begin
            if (reg_req && !msb_range) begin
               own_ack_nxt = 1'b1;
               state_nxt   = sram_access_pkg::DONE_STATE;
               case (req.addr)
                  sram_access_pkg::SRAM_ADDR: begin
                     own_rd_data_nxt[SRAM_ADDR_WIDTH-1:0] = sram_addr;
                     addr_sel = 1'b1;
                  end
                  sram_access_pkg::WR_DATA_LSB: begin
                     own_rd_data_nxt = wr_data_lsb;
                     data_sel = 1'b1;
                  end
                  sram_access_pkg::SRAM1_RD_LSB: own_rd_data_nxt = s1_rd_word[DW-1:0];
                  sram_access_pkg::SRAM2_RD_LSB: own_rd_data_nxt = s2_rd_word[DW-1:0];
                  sram_access_pkg::CMD:          cmd_sel = 1'b1;
                  sram_access_pkg::STATUS: begin
                     own_rd_data_nxt[2:0]  = count;
                     own_rd_data_nxt[15:8] = drop_count;
                  end
                  default: own_rd_data_nxt = 32'hdeadbeef;
               endcase
            end
         end
         sram_access_pkg::DONE_STATE: begin
            if (!reg_req) state_nxt = sram_access_pkg::IDLE_STATE;
         end
         default: state_nxt = sram_access_pkg::IDLE_STATE;
      endcase
   end

   // command enters the FIFO on the ack edge
   assign push = cmd_sel && !req.rd_wr_l && !full;

   always_comb begin
      push_cmd      = '0;
      push_cmd.bank = req.wr_data[0];
      push_cmd.we   = req.wr_data[1];
      push_cmd.addr[SRAM_ADDR_WIDTH-1:0] = sram_addr;
      push_cmd.data = {(req.wr_data[0] ? s2_wr_msb : s1_wr_msb), wr_data_lsb};
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= sram_access_pkg::IDLE_STATE;
         own_ack     <= 1'b0;
         own_rd_data <= '0;
         sram_addr   <= '0;
         wr_data_lsb <= '0;
         drop_count  <= '0;
      end else begin
         state       <= state_nxt;
         own_ack     <= own_ack_nxt;
         own_rd_data <= own_rd_data_nxt;
         if (addr_sel && !req.rd_wr_l) sram_addr <= req.wr_data[SRAM_ADDR_WIDTH-1:0];
         if (data_sel && !req.rd_wr_l) wr_data_lsb <= req.wr_data;
         if (cmd_sel && !req.rd_wr_l && full)
            drop_count <= drop_count + 8'd1;   // wraps at 255
      end
   end

endmodule

// ==== sram_cmd_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// command FIFO, count output is 3 bits so FIFO_DEPTH is at most 7
// a push while full is ignored
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module sram_cmd_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       push,
   input  sram_access_pkg::sram_cmd_t push_cmd,
   input  logic                       pop,
   output sram_access_pkg::sram_cmd_t head,
   output logic                       empty,
   output logic                       full,
   output logic [2:0]                 count
);

   localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   sram_access_pkg::sram_cmd_t mem [FIFO_DEPTH];

   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic                 do_push;
   logic                 do_pop;

   assign empty   = (count == 3'd0);
   assign full    = (count == 3'(FIFO_DEPTH));
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_cmd;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)      count <= count + 3'd1;
         else if (do_pop && !do_push) count <= count - 3'd1;
      end
   end

endmodule

// ==== sram_pair_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// two on-chip memories standing in for the srams, no pin timing
// head command executes on the edge that pops it
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module sram_pair_ctrl #(
   parameter int SRAM_ADDR_WIDTH = 6
) (
   input  logic                                        clk,
   input  logic                                        reset,
   input  sram_access_pkg::sram_cmd_t                  head,
   input  logic                                        empty,
   input  logic                                        sram_hold,
   output logic                                        pop,
   output logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] s1_rd_word,
   output logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] s2_rd_word
);

   localparam int WORDS = 2 ** SRAM_ADDR_WIDTH;

   logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] mem1 [WORDS];
   logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] mem2 [WORDS];
   logic [SRAM_ADDR_WIDTH-1:0]                  addr;

   assign pop  = !empty && !sram_hold;   // stall while hold is up
   assign addr = head.addr[SRAM_ADDR_WIDTH-1:0];

   // memory writes
   always_ff @(posedge clk) begin
      if (pop && head.we) begin
         if (head.bank) mem2[addr] <= head.data;
         else           mem1[addr] <= head.data;
      end
   end

   // held read words per bank
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_rd_word <= '0;
         s2_rd_word <= '0;
      end else if (pop && !head.we) begin
         if (head.bank) s2_rd_word <= mem2[addr];
         else           s1_rd_word <= mem1[addr];
      end
   end

endmodule

// ==== sram_access_top.sv ====
//////////////////////////////////////////////////////////////////////
// register window onto two 36-bit srams
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module sram_access_top #(
   parameter int SRAM_ADDR_WIDTH = 6,
   parameter int FIFO_DEPTH      = 4
) (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        reg_req,
   input  sram_access_pkg::reg_req_t                   req,
   output logic                                        reg_ack,
   output logic [sram_access_pkg::CPCI_DATA_WIDTH-1:0] reg_rd_data,
   input  logic                                        sram_hold
);

   logic                                        push, pop, full, empty;
   logic [2:0]                                  count;
   sram_access_pkg::sram_cmd_t                  push_cmd, head;
   logic [sram_access_pkg::SRAM_DATA_WIDTH-1:0] s1_rd_word, s2_rd_word;

   reg_sram_cmd #(.SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH)) u_regs (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .req         (req),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data),
      .s1_rd_word  (s1_rd_word),
      .s2_rd_word  (s2_rd_word),
      .full        (full),
      .count       (count),
      .push        (push),
      .push_cmd    (push_cmd)
   );

   sram_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk      (clk),
      .reset    (reset),
      .push     (push),
      .push_cmd (push_cmd),
      .pop      (pop),
      .head     (head),
      .empty    (empty),
      .full     (full),
      .count    (count)
   );

   sram_pair_ctrl #(.SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH)) u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .head       (head),
      .empty      (empty),
      .sram_hold  (sram_hold),
      .pop        (pop),
      .s1_rd_word (s1_rd_word),
      .s2_rd_word (s2_rd_word)
   );

endmodule

// ==== sram_access_props.sv ====
//////////////////////////////////////////////////////////////////////
// bus and FIFO handshake properties, bound into sram_access_top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module sram_access_props (
   input logic clk,
   input logic reset,
   input logic reg_ack,
   input logic push,
   input logic full,
   input logic pop,
   input logic empty,
   input logic sram_hold
);

   // ack is a single-cycle pulse per request
   ack_single_pulse: assert property (@(posedge clk) disable iff (reset) reg_ack |=> !reg_ack)
      else $error("reg_ack stayed high for two cycles");

   no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
      else $error("push while the command FIFO is full");

   no_pop_when_blocked: assert property (@(posedge clk) disable iff (reset)
      !(pop && (empty || sram_hold)))
      else $error("pop while FIFO empty or sram_hold high");

endmodule

bind sram_access_top sram_access_props u_props (
   .clk       (clk),
   .reset     (reset),
   .reg_ack   (reg_ack),
   .push      (push),
   .full      (full),
   .pop       (pop),
   .empty     (empty),
   .sram_hold (sram_hold)
);

// ==== tb_sram_access.sv ====
//////////////////////////////////////////////////////////////////////
// directed testbench, sram memories are not reset so only written
// addresses are read back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_sram_access;

   localparam int SRAM_ADDR_WIDTH = 6;
   localparam int FIFO_DEPTH      = 4;
   localparam int NUM_TESTS       = 5;
   localparam int WATCHDOG_NS     = NUM_TESTS * 2000 * 4;

   logic                      clk;
   logic                      reset;
   logic                      reg_req;
   sram_access_pkg::reg_req_t req;
   logic                      reg_ack;
   logic [31:0]               reg_rd_data;
   logic                      sram_hold;

   logic [35:0] model1 [64];   // bank 1 expected contents
   logic [35:0] model2 [64];
   logic [31:0] rng;

   sram_access_top #(
      .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH),
      .FIFO_DEPTH      (FIFO_DEPTH)
   ) UUT (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .req         (req),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data),
      .sram_hold   (sram_hold)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $fatal(1, "simulation timeout");
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // register bus
   ////////////////////////////////////////////////////////////////////
   task automatic bus_cycle(input logic rd, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      n = 0;
      @(posedge clk);
      req     <= '{rd_wr_l: rd, addr: addr, wr_data: wdata};
      reg_req <= 1'b1;
      do begin
         @(negedge clk);   // sample away from the edge
         n++;
      end while (!reg_ack && n < 50);
      if (!reg_ack) begin
         $display("no reg_ack from the DUT for register %0d", addr);
         $display("TEST FAILED");
         $fatal(1, "bus handshake timeout");
      end
      rdata = reg_rd_data;
      @(posedge clk);
      reg_req <= 1'b0;
   endtask

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b0, addr, data, unused);
   endtask

   task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
      bus_cycle(1'b1, addr, 32'h0, data);
   endtask

   // poll STATUS until every queued command has run
   task automatic wait_idle();
      logic [31:0] status;
      int          n;
      n = 0;
      do begin
         reg_read(sram_access_pkg::STATUS, status);
         n++;
      end while (status[2:0] != 3'd0 && n < 200);
      if (status[2:0] != 3'd0) begin
         $display("command FIFO never drained");
         $display("TEST FAILED");
         $fatal(1, "FIFO drain timeout");
      end
   endtask

   task automatic write_word(input logic bank, input logic [5:0] addr, input logic [35:0] word);
      reg_write(sram_access_pkg::SRAM_ADDR, {26'h0, addr});
      reg_write(sram_access_pkg::WR_DATA_LSB, word[31:0]);
      reg_write(bank ? sram_access_pkg::SRAM2_MSB_WR : sram_access_pkg::SRAM1_MSB_WR,
                {28'h0, word[35:32]});
      reg_write(sram_access_pkg::CMD, {30'h0, 1'b1, bank});   // we = 1
      if (bank) model2[addr] = word;
      else      model1[addr] = word;
   endtask

   task automatic verify_word(input string name, input logic bank, input logic [5:0] addr);
      logic [35:0] expected;
      logic [31:0] lsb;
      logic [31:0] msb;
      expected = bank ? model2[addr] : model1[addr];
      reg_write(sram_access_pkg::SRAM_ADDR, {26'h0, addr});
      reg_write(sram_access_pkg::CMD, {30'h0, 1'b0, bank});
      wait_idle();
      reg_read(bank ? sram_access_pkg::SRAM2_RD_LSB : sram_access_pkg::SRAM1_RD_LSB, lsb);
      reg_read(bank ? sram_access_pkg::SRAM2_MSB_RD : sram_access_pkg::SRAM1_MSB_RD, msb);
      check_value({name, " lsb"}, expected[31:0], lsb);
      check_value({name, " msb"}, {28'h0, expected[35:32]}, msb);
   endtask

   ////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////
   task automatic msb_register_test();
      logic [31:0] v1, v2, rd;
      reg_read(sram_access_pkg::SRAM1_MSB_WR, rd);
      check_value("msb reset s1", 32'h0, rd);
      reg_read(sram_access_pkg::SRAM2_MSB_WR, rd);
      check_value("msb reset s2", 32'h0, rd);
      reg_read(sram_access_pkg::SRAM1_MSB_RD, rd);
      check_value("msb rd reset", 32'h0, rd);
      reg_read(sram_access_pkg::SRAM2_MSB_RD, rd);
      check_value("msb rd reset s2", 32'h0, rd);
      for (int i = 0; i < 4; i++) begin
         v1 = next_rand();
         v2 = next_rand();
         reg_write(sram_access_pkg::SRAM1_MSB_WR, v1);
         reg_write(sram_access_pkg::SRAM2_MSB_WR, v2);
         reg_read(sram_access_pkg::SRAM1_MSB_WR, rd);
         check_value("msb s1", {28'h0, v1[3:0]}, rd);   // zero-extended
         reg_read(sram_access_pkg::SRAM2_MSB_WR, rd);
         check_value("msb s2", {28'h0, v2[3:0]}, rd);
      end
   endtask

   task automatic round_trip_test();
      logic [31:0] r;
      logic        bank [8];
      logic [5:0]  addr [8];
      for (int i = 0; i < 8; i++) begin
         r       = next_rand();
         bank[i] = r[0];
         addr[i] = r[6:1];
         write_word(bank[i], addr[i], {r[11:8], next_rand()});
      end
      for (int i = 0; i < 8; i++) verify_word("round trip", bank[i], addr[i]);
   endtask

   task automatic bank_independence_test();
      logic [5:0] addr;
      addr = 6'd17;
      write_word(1'b0, addr, {4'ha, next_rand()});
      write_word(1'b1, addr, {4'h5, next_rand()});
      verify_word("bank 1 word", 1'b0, addr);
      verify_word("bank 2 word", 1'b1, addr);
   endtask

   task automatic back_pressure_test();
      logic [35:0] saved [FIFO_DEPTH + 3];
      logic [31:0] status;
      for (int i = 0; i < FIFO_DEPTH + 3; i++) write_word(1'b0, 6'(40 + i), {4'h3, next_rand()});
      wait_idle();
      for (int i = 0; i < FIFO_DEPTH + 3; i++) saved[i] = model1[40 + i];
      @(posedge clk);
      sram_hold <= 1'b1;
      for (int i = 0; i < FIFO_DEPTH + 3; i++) write_word(1'b0, 6'(40 + i), {4'hc, next_rand()});
      // commands past the FIFO depth are dropped
      for (int i = FIFO_DEPTH; i < FIFO_DEPTH + 3; i++) model1[40 + i] = saved[i];
      reg_read(sram_access_pkg::STATUS, status);
      check_value("status under hold", 32'h0000_0304, status);
      @(posedge clk);
      sram_hold <= 1'b0;
      wait_idle();
      for (int i = 0; i < FIFO_DEPTH + 3; i++) verify_word("back pressure", 1'b0, 6'(40 + i));
   endtask

   task automatic unmapped_test();
      logic [3:0]  regs [5];
      logic [31:0] expected [5];
      logic [31:0] w;
      logic [31:0] rd;
      regs = '{4'd4, 4'd5, 4'd1, 4'd3, 4'd9};
      for (int i = 0; i < 4; i++) begin
         w = next_rand();
         reg_write(regs[i], w);
         case (i)
            0:       expected[i] = {26'h0, w[5:0]};   // 6-bit sram address
            1:       expected[i] = w;
            default: expected[i] = {28'h0, w[3:0]};
         endcase
      end
      expected[4] = {16'h0, 8'd3, 8'h0};   // empty FIFO and three earlier drops
      for (int a = 10; a < 16; a++) begin
         reg_read(4'(a), rd);
         check_value("unmapped read", 32'hdeadbeef, rd);
         reg_write(4'(a), next_rand());
      end
      for (int i = 0; i < 5; i++) begin
         reg_read(regs[i], rd);
         check_value("register after unmapped write", expected[i], rd);
      end
   endtask

   initial begin
      rng       = 32'h93d5_636c;
      reset     = 1'b1;
      reg_req   = 1'b0;
      req       = '0;
      sram_hold = 1'b0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      msb_register_test();
      round_trip_test();
      bank_independence_test();
      back_pressure_test();
      unmapped_test();

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
sram_access_pkg.sv
reg_sram_msb.sv
reg_sram_cmd.sv
sram_cmd_fifo.sv
sram_pair_ctrl.sv
sram_access_top.sv
sram_access_props.sv
tb_sram_access.sv

// ==== run_sim.sh ====
#!/bin/bash
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_sram_access

# keep the run status from stopping the script, the grep decides
out=$(./obj_dir/Vtb_sram_access 2>&1 || true)
echo "$out"

if grep -qx "TEST PASSED" <<< "$out"; then
   exit 0
else
   exit 1
fi
